/* dv/mul_patterns.txt */
// funct3 destination operand_a operand_b expected_result, all hex
// funct3 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
0 01 00000003 00000007 00000015
0 02 ffffffff ffffffff 00000001
0 03 80000000 00000002 00000000
0 04 12345678 00000010 23456780
0 05 fffffffe 00000003 fffffffa
1 06 00000003 00000007 00000000
1 07 ffffffff ffffffff 00000000
1 08 ffffffff 00000001 ffffffff
1 09 80000000 80000000 40000000
1 0a 80000000 7fffffff c0000000
1 0b 7fffffff 7fffffff 3fffffff
1 0c 00010000 00010000 00000001
2 0d ffffffff ffffffff ffffffff
2 0e 00000002 80000000 00000001
2 0f 80000000 ffffffff 80000000
2 10 7fffffff ffffffff 7ffffffe
2 11 fffffffe 00000003 ffffffff
3 12 ffffffff ffffffff fffffffe
3 13 80000000 80000000 40000000
3 14 80000000 00000002 00000001
3 1f 00000003 00000007 00000000
3 00 12345678 00010000 00001234

/* tb.f */
common/mul_params_pkg.sv
common/mul_ops_pkg.sv
mul_unit/mul_decode.sv
mul_unit/mul_registers.sv
mul_unit/mul_partial_stage.sv
mul_unit/mul_writeback.sv
verilog/mul_pipeline_top.sv
dv/mul_sva.sv
dv/mul_tb.sv

/* Bender.yml */
package:
  name: mul_pipeline

sources:
  - files:
      - common/mul_params_pkg.sv
      - common/mul_ops_pkg.sv
      - mul_unit/mul_decode.sv
      - mul_unit/mul_registers.sv
      - mul_unit/mul_partial_stage.sv
      - mul_unit/mul_writeback.sv
      - verilog/mul_pipeline_top.sv
  - target: test
    files:
      - dv/mul_sva.sv
      - dv/mul_tb.sv

/* dv/mul_tb.sv */
/*
 * Testbench for the multiply pipeline.
 * Runs the pattern file one launch at a time, then back-to-back streams,
 * random stalls, rejected non-multiply launches and a mid-stream flush.
 */
module mul_tb;

  localparam int STAGE_COUNT = 4;
  // Falling edges from the launch drive to the edge that sees result_valid
  localparam int LATENCY = STAGE_COUNT + 2;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int PATTERN_FIELDS = 5;
  localparam int PATTERN_WORDS = PATTERN_FIELDS * 64;

  logic        clk;
  logic        reset;
  logic [31:0] instruction;
  logic [4:0]  destination_register;
  logic [31:0] first_input;
  logic [31:0] second_input;
  logic        init_op;
  logic        stall_in;
  logic        set_nop;
  logic [31:0] result;
  logic [4:0]  result_register;
  logic        result_valid;

  logic [31:0] lfsr_state;
  logic [31:0] pattern_words [0:PATTERN_WORDS-1];
  int          pattern_count;
  int          error_count;
  int          timeout_count;
  int          results_seen;

  // Scoreboard, one entry per launched multiply
  logic [31:0] expected_results[$];
  logic [4:0]  expected_registers[$];

  mul_pipeline_top #(.STAGE_COUNT(STAGE_COUNT)) DUT (
    .clk                  (clk),
    .reset                (reset),
    .instruction          (instruction),
    .destination_register (destination_register),
    .first_input          (first_input),
    .second_input         (second_input),
    .init_op              (init_op),
    .stall_in             (stall_in),
    .set_nop              (set_nop),
    .result               (result),
    .result_register      (result_register),
    .result_valid         (result_valid)
  );

  always #4 clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  // R-type M-extension word, rs1 = x1 and rs2 = x2
  function automatic logic [31:0] encode_mul(input logic [2:0] funct3, input logic [4:0] rd);
    return {7'b000_0001, 5'd2, 5'd1, funct3, rd, 7'b011_0011};
  endfunction

  // MULH and MULHSU treat a as signed, only MULH treats b as signed
  function automatic logic [31:0] reference_result(input logic [2:0] funct3,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    logic signed [32:0] sa;
    logic signed [32:0] sb;
    logic signed [65:0] full;
    sa = $signed({((funct3 == 3'd1) || (funct3 == 3'd2)) & a[31], a});
    sb = $signed({(funct3 == 3'd1) & b[31], b});
    full = sa * sb;
    if (funct3 == 3'd0)
      return full[31:0];
    return full[63:32];
  endfunction

  task automatic check_value(input string signal_name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, signal_name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    error_count++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // One LFSR step per bit, MSB first
  task automatic take_bits(input int count, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic drive_launch(input logic [31:0] instr, input logic [4:0] rd,
                              input logic [31:0] a, input logic [31:0] b);
    instruction = instr;
    destination_register = rd;
    first_input = a;
    second_input = b;
    init_op = 1'b1;
  endtask

  task automatic drive_idle();
    init_op = 1'b0;
    instruction = 32'h0000_0013;
  endtask

  task automatic push_expected(input logic [31:0] value, input logic [4:0] rd);
    expected_results.push_back(value);
    expected_registers.push_back(rd);
  endtask

  // Random op and operands; a flushed op is launched without an entry
  task automatic random_launch(input bit expect_result);
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    take_bits(2, bits);
    funct3 = {1'b0, bits[1:0]};
    take_bits(5, bits);
    rd = bits[4:0];
    take_bits(32, a);
    take_bits(32, b);
    drive_launch(encode_mul(funct3, rd), rd, a, b);
    if (expect_result)
      push_expected(reference_result(funct3, a, b), rd);
  endtask

  // Single launch, then count falling edges until result_valid
  task automatic run_single(input logic [2:0] funct3, input logic [4:0] rd,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expected);
    int cycles;
    bit seen;
    @(negedge clk);
    drive_launch(encode_mul(funct3, rd), rd, a, b);
    push_expected(expected, rd);
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
      seen = (result_valid === 1'b1);
      drive_idle();
    end
    if (seen)
      check_value("latency", cycles, LATENCY);
    else
      report_timeout("a single multiply result");
  endtask

  task automatic expect_no_result(input int cycles, input string what);
    int i;
    for (i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      check_value(what, result_valid, 1'b0);
    end
  endtask

  // Once the first result shows up the rest must follow on every cycle
  task automatic stream_back_to_back(input int count);
    int launched;
    int seen;
    int guard;
    launched = 0;
    seen = 0;
    guard = 0;
    while (seen < count && guard < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      guard++;
      if (seen > 0)
      begin
        check_value("result_valid in stream", result_valid, 1'b1);
        seen++;
      end
      else if (result_valid === 1'b1)
        seen++;
      if (launched < count)
      begin
        random_launch(1'b1);
        launched++;
      end
      else
        drive_idle();
    end
    drive_idle();
    if (seen < count)
      report_timeout("back-to-back results");
  endtask

  // No launch is offered while stalled, as the issue logic would do
  task automatic stream_with_stalls(input int count);
    logic [31:0] bits;
    int launched;
    int guard;
    launched = 0;
    guard = 0;
    while ((launched < count || expected_results.size() != 0) && guard < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      guard++;
      take_bits(2, bits);
      stall_in = (bits[1:0] == 2'b00);
      if (!stall_in && launched < count)
      begin
        random_launch(1'b1);
        launched++;
      end
      else
        drive_idle();
    end
    stall_in = 1'b0;
    drive_idle();
    if (expected_results.size() != 0)
      report_timeout("results under random stall");
  endtask

  task automatic reject_non_multiply();
    @(negedge clk);
    // ADD
    drive_launch({7'b000_0000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b011_0011}, 5'd3, 32'd5, 32'd6);
    @(negedge clk);
    // DIV
    drive_launch({7'b000_0001, 5'd2, 5'd1, 3'b100, 5'd4, 7'b011_0011}, 5'd4, 32'd9, 32'd3);
    @(negedge clk);
    // SUB
    drive_launch({7'b010_0000, 5'd2, 5'd1, 3'b000, 5'd5, 7'b011_0011}, 5'd5, 32'd7, 32'd1);
    @(negedge clk);
    // MULW opcode belongs to RV64 and stays out of this unit
    drive_launch({7'b000_0001, 5'd2, 5'd1, 3'b000, 5'd6, 7'b011_1011}, 5'd6, 32'd2, 32'd2);
    @(negedge clk);
    drive_idle();
    expect_no_result(LATENCY + 2, "result_valid after non-multiply");
  endtask

  // Four in flight, none far enough along to finish before the flush
  task automatic flush_in_flight();
    int i;
    for (i = 0; i < 4; i++)
    begin
      @(negedge clk);
      random_launch(1'b0);
    end
    @(negedge clk);
    drive_idle();
    set_nop = 1'b1;
    @(negedge clk);
    set_nop = 1'b0;
    expect_no_result(LATENCY + 2, "result_valid after flush");
    run_single(3'd2, 5'd30, 32'hffff_fff9, 32'h0000_0100,
               reference_result(3'd2, 32'hffff_fff9, 32'h0000_0100));
  endtask

  // Compares each presented result with the oldest pending entry
  always @(posedge clk)
  begin : scoreboard
    logic [31:0] want_result;
    logic [4:0]  want_register;
    if (!reset && result_valid === 1'b1)
    begin
      if (expected_results.size() == 0)
      begin
        error_count++;
        $display("Unexpected result_valid at %0t with no multiply pending", $time);
      end
      else
      begin
        want_result = expected_results.pop_front();
        want_register = expected_registers.pop_front();
        check_value("result", result, want_result);
        check_value("result_register", result_register, want_register);
        results_seen++;
      end
    end
    if (!reset && stall_in)
      check_value("result_valid during stall", result_valid, 1'b0);
  end

  initial
  begin : main
    int i;
    clk = 1'b0;
    reset = 1'b1;
    instruction = 32'h0000_0013;
    destination_register = '0;
    first_input = '0;
    second_input = '0;
    init_op = 1'b0;
    stall_in = 1'b0;
    set_nop = 1'b0;
    lfsr_state = 32'hc771e9d5;
    error_count = 0;
    timeout_count = 0;
    results_seen = 0;

    // Fill values are never a legal funct3, so they end the pattern list
    for (i = 0; i < PATTERN_WORDS; i++)
      pattern_words[i] = 32'hbad0_0000 | i;
    $readmemh("dv/mul_patterns.txt", pattern_words);
    pattern_count = 0;
    while ((pattern_count + 1) * PATTERN_FIELDS <= PATTERN_WORDS &&
           pattern_words[pattern_count * PATTERN_FIELDS] < 4)
      pattern_count++;
    if (pattern_count == 0)
    begin
      error_count++;
      $display("No multiply patterns could be read from the pattern file");
    end

    repeat (16) @(negedge clk);
    reset = 1'b0;

    expect_no_result(LATENCY + 4, "result_valid after reset");

    for (i = 0; i < pattern_count; i++)
      run_single(pattern_words[PATTERN_FIELDS * i][2:0],
                 pattern_words[PATTERN_FIELDS * i + 1][4:0],
                 pattern_words[PATTERN_FIELDS * i + 2],
                 pattern_words[PATTERN_FIELDS * i + 3],
                 pattern_words[PATTERN_FIELDS * i + 4]);

    stream_back_to_back(12);
    stream_with_stalls(40);
    reject_non_multiply();
    flush_in_flight();

    repeat (2) @(negedge clk);
    if (expected_results.size() != 0)
    begin
      error_count++;
      $display("%0d expected results never arrived", expected_results.size());
    end

    // Failures of the bound assertions join the total
    error_count += DUT.u_sva.assertion_failures;

    $display("Checked %0d results, %0d errors, %0d of them timeouts",
             results_seen, error_count, timeout_count);
    if (error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* dv/mul_sva.sv */
/*
 * Protocol assertions for the multiply pipeline outputs.
 * Bound onto the top level; the failure count is read back by the testbench.
 */
module mul_sva (
  input logic clk,
  input logic reset,
  input logic stall_in,
  input logic set_nop,
  input logic result_valid
);

  // Number of assertion failures so far
  int assertion_failures = 0;

  // Valid is masked for the whole stall
  stall_hides_result : assert property (
    @(posedge clk) disable iff (reset) stall_in |-> !result_valid
  ) else
  begin
    assertion_failures++;
    $error("result_valid high while stall_in is high");
  end

  // Flush empties writeback in the same edge
  flush_drops_result : assert property (
    @(posedge clk) disable iff (reset) set_nop |=> !result_valid
  ) else
  begin
    assertion_failures++;
    $error("result_valid high in the cycle after set_nop");
  end

  // Checked one edge later since valid is unknown before the first edge
  reset_clears_result : assert property (
    @(posedge clk) reset |=> !result_valid
  ) else
  begin
    assertion_failures++;
    $error("result_valid high while in reset");
  end

endmodule

bind mul_pipeline_top mul_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .stall_in     (stall_in),
  .set_nop      (set_nop),
  .result_valid (result_valid)
);

/* verilog/mul_pipeline_top.sv */
/*
 * Top of the multiply unit: decode, STAGE_COUNT register plus partial
 * stage pairs, a final register holding the full product, then writeback.
 * Latency is STAGE_COUNT+2 clocks; one launch per clock.
 */
module mul_pipeline_top #(
  parameter int STAGE_COUNT = 4
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]           instruction,
  input  logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] destination_register,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]           first_input,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]           second_input,
  input  logic                                            init_op,
  input  logic                                            stall_in,
  input  logic                                            set_nop,
  output logic [mul_params_pkg::WORD_WIDTH-1:0]           result,
  output logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] result_register,
  output logic                                            result_valid
);

  localparam int WW = mul_params_pkg::WORD_WIDTH;
  localparam int PW = mul_params_pkg::PRODUCT_WIDTH;
  localparam int RW = mul_params_pkg::REGISTER_INDEX_WIDTH;

  // Element k is what register k loads
  logic [WW-1:0]        stage_instruction [0:STAGE_COUNT];
  logic [RW-1:0]        stage_destination [0:STAGE_COUNT];
  mul_ops_pkg::mul_op_e stage_op          [0:STAGE_COUNT];
  logic [PW-1:0]        stage_operand_a   [0:STAGE_COUNT];
  logic [PW-1:0]        stage_operand_b   [0:STAGE_COUNT];
  logic [PW-1:0]        stage_product     [0:STAGE_COUNT];
  logic                 stage_init        [0:STAGE_COUNT];

  // Running product as held in register k, before slice k is added
  logic [PW-1:0]        held_product      [0:STAGE_COUNT-1];

  logic [RW-1:0]        final_destination;
  mul_ops_pkg::mul_op_e final_op;
  logic [PW-1:0]        final_product;
  logic                 final_done;

  assign stage_instruction[0] = instruction;
  assign stage_destination[0] = destination_register;
  // Accumulation starts from zero
  assign stage_product[0] = '0;

  mul_decode u_decode (
    .instruction  (instruction),
    .first_input  (first_input),
    .second_input (second_input),
    .init_op      (init_op),
    .launch_valid (stage_init[0]),
    .op           (stage_op[0]),
    .operand_a    (stage_operand_a[0]),
    .operand_b    (stage_operand_b[0])
  );

  for (genvar k = 0; k < STAGE_COUNT; k++)
  begin : g_stage
    mul_registers #(.STAGE_COUNT(STAGE_COUNT)) u_reg (
      .clk                      (clk),
      .reset                    (reset),
      .instruction_in           (stage_instruction[k]),
      .destination_register_in  (stage_destination[k]),
      .op_in                    (stage_op[k]),
      .first_input_in           (stage_operand_a[k]),
      .second_input_in          (stage_operand_b[k]),
      .mul_result_in            (stage_product[k]),
      .init_op                  (stage_init[k]),
      .set_nop                  (set_nop),
      .stall_in                 (stall_in),
      .instruction_out          (stage_instruction[k+1]),
      .destination_register_out (stage_destination[k+1]),
      .op_out                   (stage_op[k+1]),
      .first_input_out          (stage_operand_a[k+1]),
      .second_input_out         (stage_operand_b[k+1]),
      .mul_result_out           (held_product[k]),
      .set_nop_out              (),
      .op_done                  (stage_init[k+1])
    );

    // Works on the registered operands, result goes to the next register
    mul_partial_stage #(.STAGE_COUNT(STAGE_COUNT), .STAGE_INDEX(k)) u_partial (
      .first_input    (stage_operand_a[k+1]),
      .second_input   (stage_operand_b[k+1]),
      .mul_result_in  (held_product[k]),
      .mul_result_out (stage_product[k+1])
    );
  end

  // Holds the complete product; operands are no longer needed here
  mul_registers #(.STAGE_COUNT(STAGE_COUNT)) u_final_reg (
    .clk                      (clk),
    .reset                    (reset),
    .instruction_in           (stage_instruction[STAGE_COUNT]),
    .destination_register_in  (stage_destination[STAGE_COUNT]),
    .op_in                    (stage_op[STAGE_COUNT]),
    .first_input_in           (stage_operand_a[STAGE_COUNT]),
    .second_input_in          (stage_operand_b[STAGE_COUNT]),
    .mul_result_in            (stage_product[STAGE_COUNT]),
    .init_op                  (stage_init[STAGE_COUNT]),
    .set_nop                  (set_nop),
    .stall_in                 (stall_in),
    .instruction_out          (),
    .destination_register_out (final_destination),
    .op_out                   (final_op),
    .first_input_out          (),
    .second_input_out         (),
    .mul_result_out           (final_product),
    .set_nop_out              (),
    .op_done                  (final_done)
  );

  mul_writeback u_writeback (
    .clk                     (clk),
    .reset                   (reset),
    .op                      (final_op),
    .destination_register_in (final_destination),
    .mul_result_in           (final_product),
    .init_op                 (final_done),
    .stall_in                (stall_in),
    .set_nop                 (set_nop),
    .result                  (result),
    .result_register         (result_register),
    .result_valid            (result_valid)
  );

endmodule

/* mul_unit/mul_writeback.sv */
/*
 * Last register of the multiply pipe.
 * Picks the low or high product word by op kind and presents it with the
 * destination index. result_valid drops while the core is stalled.
 */
module mul_writeback (
  input  logic                                            clk,
  input  logic                                            reset,
  input  mul_ops_pkg::mul_op_e                            op,
  input  logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] destination_register_in,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        mul_result_in,
  input  logic                                            init_op,
  input  logic                                            stall_in,
  input  logic                                            set_nop,
  output logic [mul_params_pkg::WORD_WIDTH-1:0]           result,
  output logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] result_register,
  output logic                                            result_valid
);

  localparam int WW = mul_params_pkg::WORD_WIDTH;
  localparam int PW = mul_params_pkg::PRODUCT_WIDTH;

  logic [WW-1:0] selected_word;
  logic          valid_q;

  // MUL wants bits 31:0, the MULH family bits 63:32
  assign selected_word = (op == mul_ops_pkg::MUL_LOW) ? mul_result_in[WW-1:0]
                                                       : mul_result_in[PW-1:WW];

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_q <= 1'b0;
    else if (set_nop)
      valid_q <= 1'b0;
    else if (!stall_in)
      valid_q <= init_op;
  end

  always_ff @(posedge clk)
  begin
    if (set_nop)
    begin
      result <= '0;
      result_register <= '0;
    end
    else if (!stall_in && init_op)
    begin
      result <= selected_word;
      result_register <= destination_register_in;
    end
  end

  // Held result reappears once the stall lifts
  assign result_valid = valid_q & ~stall_in;

endmodule

/* mul_unit/mul_partial_stage.sv */
/*
 * One slice of the shift-and-add multiplier, combinational.
 * Stage STAGE_INDEX multiplies the multiplicand by its slice of the
 * multiplier and accumulates into the running product.
 */
module mul_partial_stage #(
  parameter int STAGE_COUNT = 4,
  parameter int STAGE_INDEX = 0
) (
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0] first_input,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0] second_input,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0] mul_result_in,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0] mul_result_out
);

  localparam int PW = mul_params_pkg::PRODUCT_WIDTH;
  localparam int SLICE_WIDTH = PW / STAGE_COUNT;

  // Bit position of this slice in the multiplier
  localparam int SLICE_LSB = STAGE_INDEX * SLICE_WIDTH;

  logic [SLICE_WIDTH-1:0] multiplier_slice;
  logic [PW-1:0]          slice_wide;
  logic [PW-1:0]          partial_product;
  logic [PW-1:0]          shifted_product;

  assign multiplier_slice = second_input[SLICE_LSB +: SLICE_WIDTH];

  // Slice is always an unsigned digit
  // Sign lives in the extended upper bits of the multiplier
  assign slice_wide = {{(PW - SLICE_WIDTH){1'b0}}, multiplier_slice};

  // Bits beyond the product width fall away
  assign partial_product = first_input * slice_wide;

  assign shifted_product = partial_product << SLICE_LSB;

  // Running sum, modulo 2^PW
  assign mul_result_out = mul_result_in + shifted_product;

endmodule

/* mul_unit/mul_registers.sv */
/*
 * Register between two multiply stages.
 * Carries instruction, destination, op kind, both operands and the running
 * product. Flush beats stall, stall beats load.
 */
module mul_registers #(
  parameter int STAGE_COUNT = 4
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]           instruction_in,
  input  logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] destination_register_in,
  input  mul_ops_pkg::mul_op_e                            op_in,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        first_input_in,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        second_input_in,
  input  logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        mul_result_in,
  input  logic                                            init_op,
  input  logic                                            set_nop,
  input  logic                                            stall_in,
  output logic [mul_params_pkg::WORD_WIDTH-1:0]           instruction_out,
  output logic [mul_params_pkg::REGISTER_INDEX_WIDTH-1:0] destination_register_out,
  output mul_ops_pkg::mul_op_e                            op_out,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        first_input_out,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        second_input_out,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0]        mul_result_out,
  output logic                                            set_nop_out,
  output logic                                            op_done
);

  // Multiplier slices must tile the product exactly
  if (mul_params_pkg::PRODUCT_WIDTH % STAGE_COUNT != 0)
  begin : g_bad_stage_count
    $error("STAGE_COUNT must divide the product width");
  end

  // Valid and flush marker
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      op_done <= 1'b0;
      set_nop_out <= 1'b0;
    end
    else if (set_nop)
    begin
      op_done <= 1'b0;
      set_nop_out <= 1'b1;
    end
    else if (!stall_in)
    begin
      // An empty slot just drops its valid
      op_done <= init_op;
      if (init_op)
        set_nop_out <= 1'b0;
    end
  end

  // Payload, held on stall
  always_ff @(posedge clk)
  begin
    if (set_nop)
    begin
      instruction_out <= mul_params_pkg::NOP_INSTRUCTION;
      destination_register_out <= '0;
      op_out <= mul_ops_pkg::MUL_LOW;
      first_input_out <= '0;
      second_input_out <= '0;
      mul_result_out <= '0;
    end
    else if (!stall_in && init_op)
    begin
      instruction_out <= instruction_in;
      destination_register_out <= destination_register_in;
      op_out <= op_in;
      first_input_out <= first_input_in;
      second_input_out <= second_input_in;
      mul_result_out <= mul_result_in;
    end
  end

endmodule

/* mul_unit/mul_decode.sv */
/*
 * Front end of the multiply pipeline, purely combinational.
 * Picks MUL/MULH/MULHSU/MULHU out of the instruction word and widens
 * both operands so a plain modulo-2^64 product gives the right answer.
 */
module mul_decode (
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]    instruction,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]    first_input,
  input  logic [mul_params_pkg::WORD_WIDTH-1:0]    second_input,
  input  logic                                     init_op,
  output logic                                     launch_valid,
  output mul_ops_pkg::mul_op_e                     op,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0] operand_a,
  output logic [mul_params_pkg::PRODUCT_WIDTH-1:0] operand_b
);

  localparam int EXT_WIDTH = mul_params_pkg::PRODUCT_WIDTH - mul_params_pkg::WORD_WIDTH;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       is_mul;
  logic       a_signed;
  logic       b_signed;

  // Standard R-type field positions
  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // funct3 values 1xx are the divide and remainder ops
  assign is_mul = (opcode == mul_ops_pkg::OPCODE_OP) &&
                  (funct7 == mul_ops_pkg::FUNCT7_MULDIV) && !funct3[2];

  always_comb
  begin
    case (funct3)
      mul_ops_pkg::FUNCT3_MULH:   op = mul_ops_pkg::MUL_HIGH_SS;
      mul_ops_pkg::FUNCT3_MULHSU: op = mul_ops_pkg::MUL_HIGH_SU;
      mul_ops_pkg::FUNCT3_MULHU:  op = mul_ops_pkg::MUL_HIGH_UU;
      default:                    op = mul_ops_pkg::MUL_LOW;
    endcase
  end

  // MUL only keeps the low word so either extension works there
  assign a_signed = (op == mul_ops_pkg::MUL_HIGH_SS) || (op == mul_ops_pkg::MUL_HIGH_SU);
  assign b_signed = (op == mul_ops_pkg::MUL_HIGH_SS);

  assign operand_a = {{EXT_WIDTH{a_signed & first_input[31]}}, first_input};
  assign operand_b = {{EXT_WIDTH{b_signed & second_input[31]}}, second_input};

  // Non-multiply instructions never enter the pipe
  assign launch_valid = init_op & is_mul;

endmodule

/* common/mul_ops_pkg.sv */
/*
 * Multiply operation kinds and the RV32M fields that select them.
 * The decoder maps funct3 onto mul_op_e; later stages only see the enum.
 */
package mul_ops_pkg;

  // Low word, or high word with the given operand signedness
  typedef enum logic [1:0] {
    MUL_LOW     = 2'd0,
    MUL_HIGH_SS = 2'd1,
    MUL_HIGH_SU = 2'd2,
    MUL_HIGH_UU = 2'd3
  } mul_op_e;

  // R-type integer opcode and the M-extension funct7
  localparam logic [6:0] OPCODE_OP = 7'b011_0011;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

  // funct3 of the four multiply instructions
  localparam logic [2:0] FUNCT3_MUL = 3'b000;
  localparam logic [2:0] FUNCT3_MULH = 3'b001;
  localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
  localparam logic [2:0] FUNCT3_MULHU = 3'b011;

endpackage

/* common/mul_params_pkg.sv */
/*
 * Widths and constant encodings shared by the multiply unit.
 * Modules refer to these by scoped name; nothing here depends on
 * the stage count chosen at the top level.
 */
package mul_params_pkg;

  // Operand and instruction word
  localparam int WORD_WIDTH = 32;

  // Full product of two words
  localparam int PRODUCT_WIDTH = 2 * WORD_WIDTH;

  // Index into the 32-entry integer register file
  localparam int REGISTER_INDEX_WIDTH = 5;

  // addi x0, x0, 0
  // A flushed stage carries this so downstream logic sees a harmless op
  localparam logic [WORD_WIDTH-1:0] NOP_INSTRUCTION = 32'h0000_0013;

endpackage
